/* design/bus_defs.svh */
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// Byte address and data word widths
`define BUS_ADDR_W 12
`define BUS_DATA_W 32

// On-chip RAM size in words
`define RAM_DEPTH 1024

// Waitrequest cycles per transfer, 0 to 7
`define RAM_WAIT 2

`endif

/* design/bus_pkg.sv */
`default_nettype none

`include "bus_defs.svh"

package bus_pkg;

  typedef logic [`BUS_ADDR_W-1:0] addr_t;    // Byte address
  typedef logic [`BUS_DATA_W-1:0] word_t;
  typedef logic [`BUS_DATA_W/8-1:0] byteen_t;  // One bit per byte lane

  // Crossbar grant
  typedef enum logic [1:0] {
    XBAR_IDLE,
    XBAR_INSTR,
    XBAR_DATA
  } xbar_state_t;

endpackage

`default_nettype wire

/* design/instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            fetch_enable,
  input  wire bus_pkg::addr_t  start_pc,
  input  wire logic            fetch_ready,
  output logic                 fetch_valid,
  output bus_pkg::addr_t       fetch_pc,
  output bus_pkg::word_t       fetch_word,
  output bus_pkg::addr_t       instr_address,
  output logic                 instr_read,
  input  wire bus_pkg::word_t  instr_readdata,
  input  wire logic            instr_readdatavalid,
  input  wire logic            instr_waitrequest
);
  import bus_pkg::*;

  addr_t pc;
  logic  enable_q;
  logic  start_req;  // Restart requested while a read was in flight
  logic  pending;    // Read accepted, data not yet back
  logic  busy;
  logic  en_rise;
  logic  issue;

  assign en_rise = fetch_enable && !enable_q;
  assign busy = instr_read || pending;

  // One read at a time, only when the output slot is free next cycle
  assign issue = fetch_enable && !en_rise && !start_req && !busy &&
                 (!fetch_valid || fetch_ready);

  assign instr_address = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      enable_q    <= 1'b0;
      start_req   <= 1'b0;
      pending     <= 1'b0;
      instr_read  <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      enable_q <= fetch_enable;

      if (en_rise || start_req) begin
        start_req <= busy;
      end

      if (issue) begin
        instr_read <= 1'b1;
      end else if (instr_read && !instr_waitrequest) begin
        instr_read <= 1'b0;
        pending    <= 1'b1;
      end else if (pending && instr_readdatavalid) begin
        pending <= 1'b0;
      end

      if (fetch_valid && fetch_ready) begin
        fetch_valid <= 1'b0;
      end
      if (pending && instr_readdatavalid) begin
        fetch_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((en_rise || start_req) && !busy) begin
      pc <= start_pc;
    end else if (pending && instr_readdatavalid) begin
      pc <= pc + addr_t'(4);  // Next sequential word
    end

    if (pending && instr_readdatavalid) begin
      fetch_pc   <= pc;
      fetch_word <= instr_readdata;
    end
  end

endmodule

`default_nettype wire

/* design/data_access.sv */
`timescale 1ns/1ps
`default_nettype none

module data_access (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             cmd_valid,
  input  wire logic             cmd_write,
  input  wire bus_pkg::addr_t   cmd_addr,
  input  wire bus_pkg::word_t   cmd_wdata,
  input  wire bus_pkg::byteen_t cmd_byteen,
  output logic                  cmd_ready,
  output logic                  rsp_valid,
  output bus_pkg::word_t        rsp_rdata,
  output bus_pkg::addr_t        data_address,
  output bus_pkg::byteen_t      data_byteenable,
  output logic                  data_read,
  output logic                  data_write,
  output bus_pkg::word_t        data_writedata,
  input  wire bus_pkg::word_t   data_readdata,
  input  wire logic             data_readdatavalid,
  input  wire logic             data_waitrequest
);
  import bus_pkg::*;

  typedef enum logic [1:0] {
    DA_IDLE,
    DA_REQ,
    DA_WAIT
  } da_state_t;

  da_state_t state;
  logic      cmd_take;
  logic      wr_done;
  logic      rd_done;

  assign cmd_take = (state == DA_IDLE) && cmd_valid && cmd_ready;
  assign wr_done = (state == DA_REQ) && data_write && !data_waitrequest;
  assign rd_done = (state == DA_WAIT) && data_readdatavalid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= DA_IDLE;
      cmd_ready  <= 1'b0;
      rsp_valid  <= 1'b0;
      data_read  <= 1'b0;
      data_write <= 1'b0;
    end else begin
      rsp_valid <= wr_done || rd_done;
      case (state)
        DA_IDLE: begin
          cmd_ready <= !cmd_take;
          if (cmd_take) begin
            data_read  <= !cmd_write;
            data_write <= cmd_write;
            state      <= DA_REQ;
          end
        end
        DA_REQ: begin
          if (!data_waitrequest) begin  // Accepted
            data_read  <= 1'b0;
            data_write <= 1'b0;
            cmd_ready  <= data_write;
            state      <= data_write ? DA_IDLE : DA_WAIT;
          end
        end
        default: begin
          if (data_readdatavalid) begin
            cmd_ready <= 1'b1;
            state     <= DA_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take) begin
      data_address    <= cmd_addr;
      data_writedata  <= cmd_wdata;
      data_byteenable <= cmd_byteen;
    end
    if (wr_done) begin
      rsp_rdata <= '0;
    end else if (rd_done) begin
      rsp_rdata <= data_readdata;
    end
  end

endmodule

`default_nettype wire

/* design/bus_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_crossbar (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire bus_pkg::addr_t   instr_address,
  input  wire logic             instr_read,
  output bus_pkg::word_t        instr_readdata,
  output logic                  instr_readdatavalid,
  output logic                  instr_waitrequest,
  input  wire bus_pkg::addr_t   data_address,
  input  wire bus_pkg::byteen_t data_byteenable,
  input  wire logic             data_read,
  input  wire logic             data_write,
  input  wire bus_pkg::word_t   data_writedata,
  output bus_pkg::word_t        data_readdata,
  output logic                  data_readdatavalid,
  output logic                  data_waitrequest,
  output bus_pkg::addr_t        mem_address,
  output bus_pkg::byteen_t      mem_byteenable,
  output logic                  mem_read,
  output logic                  mem_write,
  output bus_pkg::word_t        mem_writedata,
  input  wire bus_pkg::word_t   mem_readdata,
  input  wire logic             mem_readdatavalid,
  input  wire logic             mem_waitrequest
);
  import bus_pkg::*;

  xbar_state_t state;
  logic        rd_pending;  // Read accepted, data still to come
  logic        instr_req;
  logic        data_req;
  logic        granted_req;

  assign instr_req = instr_read;
  assign data_req = data_read || data_write;
  assign granted_req = (state == XBAR_DATA) ? data_req : instr_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= XBAR_IDLE;
      rd_pending <= 1'b0;
    end else begin
      if (mem_read && !mem_waitrequest) begin
        rd_pending <= 1'b1;
      end else if (mem_readdatavalid) begin
        rd_pending <= 1'b0;
      end

      if (state == XBAR_IDLE) begin
        if (data_req) state <= XBAR_DATA;  // Data side wins
        else if (instr_req) state <= XBAR_INSTR;
      end else if ((mem_write && !mem_waitrequest) || mem_readdatavalid) begin
        state <= XBAR_IDLE;
      end else if (!granted_req && !rd_pending) begin
        state <= XBAR_IDLE;
      end
    end
  end

  always_comb begin
    mem_address         = '0;
    mem_byteenable      = '0;
    mem_read            = 1'b0;
    mem_write           = 1'b0;
    mem_writedata       = '0;
    instr_readdata      = '0;
    instr_readdatavalid = 1'b0;
    instr_waitrequest   = instr_req;  // Stall while not granted
    data_readdata       = '0;
    data_readdatavalid  = 1'b0;
    data_waitrequest    = data_req;
    case (state)
      XBAR_INSTR: begin
        mem_address         = instr_address;
        mem_byteenable      = '1;
        mem_read            = instr_read;
        instr_readdata      = mem_readdata;
        instr_readdatavalid = mem_readdatavalid;
        instr_waitrequest   = mem_waitrequest;
      end
      XBAR_DATA: begin
        mem_address        = data_address;
        mem_byteenable     = data_byteenable;
        mem_read           = data_read;
        mem_write          = data_write;
        mem_writedata      = data_writedata;
        data_readdata      = mem_readdata;
        data_readdatavalid = mem_readdatavalid;
        data_waitrequest   = mem_waitrequest;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/sram_agent.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module sram_agent (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire bus_pkg::addr_t   mem_address,
  input  wire bus_pkg::byteen_t mem_byteenable,
  input  wire logic             mem_read,
  input  wire logic             mem_write,
  input  wire bus_pkg::word_t   mem_writedata,
  output bus_pkg::word_t        mem_readdata,
  output logic                  mem_readdatavalid,
  output logic                  mem_waitrequest
);
  import bus_pkg::*;

  localparam int IDX_W = $clog2(`RAM_DEPTH);

  word_t            mem [`RAM_DEPTH];
  logic [IDX_W-1:0] word_idx;
  logic [2:0]       wait_cnt;  // Wait cycles spent on this transfer
  logic             req;
  logic             accept;

  assign word_idx = mem_address[IDX_W+1:2];
  assign req = mem_read || mem_write;
  assign mem_waitrequest = req && (wait_cnt != 3'(`RAM_WAIT));
  assign accept = req && !mem_waitrequest;

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt          <= '0;
      mem_readdatavalid <= 1'b0;
    end else begin
      mem_readdatavalid <= accept && mem_read;
      if (accept) begin
        wait_cnt <= '0;  // Ready for the next request
      end else if (mem_waitrequest) begin
        wait_cnt <= wait_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && mem_write) begin
      for (int b = 0; b < `BUS_DATA_W/8; b++) begin
        if (mem_byteenable[b]) begin
          mem[word_idx][8*b +: 8] <= mem_writedata[8*b +: 8];
        end
      end
    end
    if (accept && mem_read) begin
      mem_readdata <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

/* design/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             fetch_enable,
  input  wire bus_pkg::addr_t   start_pc,
  input  wire logic             fetch_ready,
  output logic                  fetch_valid,
  output bus_pkg::addr_t        fetch_pc,
  output bus_pkg::word_t        fetch_word,
  input  wire logic             cmd_valid,
  input  wire logic             cmd_write,
  input  wire bus_pkg::addr_t   cmd_addr,
  input  wire bus_pkg::word_t   cmd_wdata,
  input  wire bus_pkg::byteen_t cmd_byteen,
  output logic                  cmd_ready,
  output logic                  rsp_valid,
  output bus_pkg::word_t        rsp_rdata
);
  import bus_pkg::*;

  // Instruction link, read only
  addr_t   instr_address;
  logic    instr_read;
  word_t   instr_readdata;
  logic    instr_readdatavalid;
  logic    instr_waitrequest;

  addr_t   data_address;
  byteen_t data_byteenable;
  logic    data_read;
  logic    data_write;
  word_t   data_writedata;
  word_t   data_readdata;
  logic    data_readdatavalid;
  logic    data_waitrequest;

  // Shared link to the RAM
  addr_t   mem_address;
  byteen_t mem_byteenable;
  logic    mem_read;
  logic    mem_write;
  word_t   mem_writedata;
  word_t   mem_readdata;
  logic    mem_readdatavalid;
  logic    mem_waitrequest;

  instr_fetch instr_fetch0 (.*);

  data_access data_access0 (.*);

  bus_crossbar bus_crossbar0 (.*);

  sram_agent sram_agent0 (.*);

endmodule

`default_nettype wire

/* bench/mem_subsystem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_properties (
  input wire logic           clk,
  input wire logic           reset,
  input wire bus_pkg::addr_t mem_address,
  input wire logic           mem_read,
  input wire logic           mem_write,
  input wire bus_pkg::word_t mem_writedata,
  input wire logic           mem_waitrequest,
  input wire logic           mem_readdatavalid,
  input wire logic           instr_read,
  input wire logic           instr_waitrequest,
  input wire logic           instr_readdatavalid,
  input wire logic           data_read,
  input wire logic           data_waitrequest,
  input wire logic           data_readdatavalid
);
  import bus_pkg::*;

  int unsigned violations = 0;  // Read back at the end of the run

  property p_no_read_and_write;
    @(posedge clk) disable iff (reset) !(mem_read && mem_write);
  endproperty

  // Stalled request keeps its command and payload
  property p_stable_while_waiting;
    @(posedge clk) disable iff (reset)
      (mem_read || mem_write) && mem_waitrequest |=>
        $stable(mem_address) && $stable(mem_read) && $stable(mem_write) &&
        $stable(mem_writedata);
  endproperty

  property p_readdatavalid_after_read;
    @(posedge clk) disable iff (reset)
      mem_readdatavalid |-> $past(mem_read && !mem_waitrequest);
  endproperty

  // Read data only reaches the manager whose read was accepted
  property p_instr_gets_own_data;
    @(posedge clk) disable iff (reset)
      instr_readdatavalid |-> $past(instr_read && !instr_waitrequest);
  endproperty

  property p_data_gets_own_data;
    @(posedge clk) disable iff (reset)
      data_readdatavalid |-> $past(data_read && !data_waitrequest);
  endproperty

  property p_readdatavalid_routed;
    @(posedge clk) disable iff (reset)
      mem_readdatavalid |-> (instr_readdatavalid || data_readdatavalid);
  endproperty

  a_no_read_and_write: assert property (p_no_read_and_write)
  else begin
    $error("mem_read and mem_write high together");
    violations++;
  end
  a_stable_while_waiting: assert property (p_stable_while_waiting)
  else begin
    $error("mem request changed during waitrequest");
    violations++;
  end
  a_readdatavalid_after_read: assert property (p_readdatavalid_after_read)
  else begin
    $error("mem_readdatavalid without an accepted read");
    violations++;
  end
  a_instr_gets_own_data: assert property (p_instr_gets_own_data)
  else begin
    $error("instr_readdatavalid without an accepted instruction read");
    violations++;
  end
  a_data_gets_own_data: assert property (p_data_gets_own_data)
  else begin
    $error("data_readdatavalid without an accepted data read");
    violations++;
  end
  a_readdatavalid_routed: assert property (p_readdatavalid_routed)
  else begin
    $error("mem_readdatavalid reached no manager");
    violations++;
  end

endmodule

`default_nettype wire

/* bench/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module mem_subsystem_tb;
  import bus_pkg::*;

  localparam int N_BASIC = 16;     // Words used by the load/store phases
  localparam int N_MIXED = 40;     // Commands run beside the fetch stream
  localparam int FETCH_N = 40;
  localparam int PRELOAD_N = 64;   // Fetch region starts at word 0
  localparam int DATA_BASE = 512;  // Data region in the upper half
  localparam int N_CMDS = 4*N_BASIC + PRELOAD_N + N_MIXED;
  localparam int WORST_LAT = 4*(`RAM_WAIT + 3);
  localparam int CYCLE_LIMIT = (N_CMDS + FETCH_N)*WORST_LAT + 1000;

  logic    clk;
  logic    reset;
  logic    fetch_enable;
  addr_t   start_pc;
  logic    fetch_ready;
  logic    fetch_valid;
  addr_t   fetch_pc;
  word_t   fetch_word;
  logic    cmd_valid;
  logic    cmd_write;
  addr_t   cmd_addr;
  word_t   cmd_wdata;
  byteen_t cmd_byteen;
  logic    cmd_ready;
  logic    rsp_valid;
  word_t   rsp_rdata;

  word_t shadow [`RAM_DEPTH];
  logic  written [`RAM_DEPTH];
  word_t expect_q [$];  // Responses still to come, in order
  int    store_idx [N_BASIC];
  int    errors;
  int    cmd_count;
  int    rsp_count;
  int    fetch_count;
  int    cycles;
  addr_t next_pc;
  logic  hold_q;        // Fetch word stalled last cycle
  addr_t hold_pc;
  word_t hold_word;
  logic  fetch_stop;

  mem_subsystem dut0 (.*);

  bind bus_crossbar mem_subsystem_properties props0 (
    .clk                 (clk),
    .reset               (reset),
    .mem_address         (mem_address),
    .mem_read            (mem_read),
    .mem_write           (mem_write),
    .mem_writedata       (mem_writedata),
    .mem_waitrequest     (mem_waitrequest),
    .mem_readdatavalid   (mem_readdatavalid),
    .instr_read          (instr_read),
    .instr_waitrequest   (instr_waitrequest),
    .instr_readdatavalid (instr_readdatavalid),
    .data_read           (data_read),
    .data_waitrequest    (data_waitrequest),
    .data_readdatavalid  (data_readdatavalid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic addr_t word_addr(input int idx);
    return addr_t'(idx << 2);
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    assert (got === exp)
    else begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle_outputs(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      assert ({rsp_valid, fetch_valid, dut0.mem_read, dut0.mem_write} === 4'b0)
      else begin
        $display("error at %0t: rsp_valid=%b fetch_valid=%b mem_read=%b mem_write=%b, expected 0",
                 $time, rsp_valid, fetch_valid, dut0.mem_read, dut0.mem_write);
        errors++;
      end
      // Ready one cycle after reset falls
      assert (cmd_ready === (i != 0))
      else begin
        $display("error at %0t: cmd_ready is %b, expected %b", $time, cmd_ready, i != 0);
        errors++;
      end
    end
  endtask

  // Drives one command, waits for it to move, records the expected response
  task automatic send_command(input logic wr, input addr_t addr, input word_t wdata,
                              input byteen_t be);
    int idx;
    idx = int'(addr[`BUS_ADDR_W-1:2]);
    @(negedge clk);
    cmd_valid  = 1'b1;
    cmd_write  = wr;
    cmd_addr   = addr;
    cmd_wdata  = wdata;
    cmd_byteen = be;
    do @(posedge clk); while (!cmd_ready);
    if (wr) begin
      for (int b = 0; b < `BUS_DATA_W/8; b++) begin
        if (be[b]) shadow[idx][8*b +: 8] = wdata[8*b +: 8];
      end
      written[idx] = 1'b1;
      expect_q.push_back('0);
    end else begin
      expect_q.push_back(shadow[idx]);
    end
    cmd_count++;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_responses();
    while (expect_q.size() != 0) @(negedge clk);
  endtask

  task automatic run_basic_stores();
    for (int i = 0; i < N_BASIC; i++) begin
      store_idx[i] = DATA_BASE + $urandom_range(0, `RAM_DEPTH - DATA_BASE - 1);
      send_command(1'b1, word_addr(store_idx[i]), $urandom, '1);
    end
    for (int i = 0; i < N_BASIC; i++) begin
      send_command(1'b0, word_addr(store_idx[i]), '0, '1);
    end
  endtask

  // Only words already written, so unwritten bytes never show up
  task automatic run_partial_stores();
    int idx;
    for (int i = 0; i < N_BASIC; i++) begin
      idx = store_idx[$urandom_range(0, N_BASIC - 1)];
      send_command(1'b1, word_addr(idx), $urandom, byteen_t'($urandom));
      send_command(1'b0, word_addr(idx), '0, '1);
    end
  endtask

  task automatic preload_fetch_region();
    for (int i = 0; i < PRELOAD_N; i++) begin
      send_command(1'b1, word_addr(i), $urandom, '1);
    end
  endtask

  task automatic run_mixed_commands();
    int idx;
    for (int i = 0; i < N_MIXED; i++) begin
      idx = store_idx[$urandom_range(0, N_BASIC - 1)];
      repeat ($urandom_range(0, 3)) @(negedge clk);
      if ($urandom_range(0, 1) == 1) begin
        send_command(1'b1, word_addr(idx), $urandom, byteen_t'($urandom));
      end else begin
        send_command(1'b0, word_addr(idx), '0, '1);
      end
    end
  endtask

  task automatic pace_fetch_ready();
    while (!fetch_stop) begin
      @(negedge clk);
      fetch_ready = 1'b0;
      repeat ($urandom_range(1, 5)) @(negedge clk);
      fetch_ready = 1'b1;
      repeat ($urandom_range(1, 4)) @(negedge clk);
    end
    fetch_ready = 1'b1;
  endtask

  task automatic stop_fetch_after();
    while (fetch_count < FETCH_N) @(negedge clk);
    fetch_enable = 1'b0;
    fetch_stop   = 1'b1;
  endtask

  task automatic run_fetch_with_traffic();
    int start_word;
    start_word = $urandom_range(0, 15);
    @(negedge clk);
    start_pc     = word_addr(start_word);
    next_pc      = word_addr(start_word);
    fetch_enable = 1'b1;
    fork
      run_mixed_commands();
      pace_fetch_ready();
      stop_fetch_after();
    join
  endtask

  // Lets the read in flight return and its word move
  task automatic wait_fetch_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      @(posedge clk);
      if (fetch_valid || dut0.instr_read) quiet = 0;
      else quiet++;
    end
  endtask

  always @(posedge clk) begin
    if (!reset && rsp_valid) begin
      rsp_count++;
      if (expect_q.size() == 0) begin
        $display("error at %0t: rsp_valid pulsed with no command outstanding", $time);
        errors++;
      end else begin
        compare_word("rsp_rdata", rsp_rdata, expect_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      hold_q = 1'b0;
    end else begin
      if (hold_q) begin
        assert (fetch_valid === 1'b1)
        else begin
          $display("error at %0t: fetch_valid is %b, expected 1 while stalled", $time, fetch_valid);
          errors++;
        end
        compare_word("fetch_pc", word_t'(fetch_pc), word_t'(hold_pc));
        compare_word("fetch_word", fetch_word, hold_word);
      end
      if (fetch_valid && fetch_ready) begin
        fetch_count++;
        compare_word("fetch_pc", word_t'(fetch_pc), word_t'(next_pc));
        assert (written[fetch_pc[`BUS_ADDR_W-1:2]] === 1'b1)
        else begin
          $display("error at %0t: fetch went past the preloaded region", $time);
          errors++;
        end
        compare_word("fetch_word", fetch_word, shadow[fetch_pc[`BUS_ADDR_W-1:2]]);
        next_pc = fetch_pc + addr_t'(4);
      end
      hold_q    = fetch_valid && !fetch_ready;
      hold_pc   = fetch_pc;
      hold_word = fetch_word;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no finish after %0d cycles, %0d responses outstanding",
               cycles, expect_q.size());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    void'($urandom(55563));
    reset        = 1'b1;
    fetch_enable = 1'b0;
    start_pc     = '0;
    fetch_ready  = 1'b1;
    cmd_valid    = 1'b0;
    cmd_write    = 1'b0;
    cmd_addr     = '0;
    cmd_wdata    = '0;
    cmd_byteen   = '0;
    fetch_stop   = 1'b0;
    next_pc      = '0;
    hold_q       = 1'b0;
    for (int i = 0; i < `RAM_DEPTH; i++) written[i] = 1'b0;

    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_idle_outputs(4);
    run_basic_stores();
    wait_responses();
    run_partial_stores();
    wait_responses();
    preload_fetch_region();
    wait_responses();
    run_fetch_with_traffic();
    wait_responses();
    wait_fetch_quiet();

    if (rsp_count != cmd_count) begin
      $display("error: %0d commands were sent but %0d responses came back", cmd_count, rsp_count);
      errors++;
    end

    $display("done: %0d errors, %0d assertion failures, %0d commands, %0d responses, %0d fetches",
             errors, dut0.bus_crossbar0.props0.violations, cmd_count, rsp_count, fetch_count);
    if (errors == 0 && dut0.bus_crossbar0.props0.violations == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/bus_pkg.sv
design/instr_fetch.sv
design/data_access.sv
design/bus_crossbar.sv
design/sram_agent.sv
design/mem_subsystem.sv
bench/mem_subsystem_properties.sv
bench/mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/bus_pkg.sv
      - design/instr_fetch.sv
      - design/data_access.sv
      - design/bus_crossbar.sv
      - design/sram_agent.sv
      - design/mem_subsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/mem_subsystem_properties.sv
      - bench/mem_subsystem_tb.sv
